// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := dma_write_tb
FILELIST := sim.f
PASS_MSG := Testbench passed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: design/dma_axi_burst_writer.sv
`timescale 1ns/1ns
`default_nettype none

module dma_axi_burst_writer
   import dma_axi_pkg::*;
   import dma_xfer_pkg::*;
(
   input  wire                     clk_i,
   input  wire                     rst_n_i,
   input  wire burst_cmd_t         cmd_i,
   input  wire                     cmd_empty_i,
   output logic                    cmd_pop_o,
   input  wire [AXI_DATA_W-1:0]    data_i,
   input  wire                     data_empty_i,
   output logic                    data_pop_o,
   output logic [AXI_ADDR_W-1:0]   awaddr_o,
   output logic [AXI_LEN_W-1:0]    awlen_o,
   output logic [1:0]              awburst_o,
   output logic [2:0]              awsize_o,
   output logic                    awvalid_o,
   input  wire                     awready_i,
   output logic [AXI_DATA_W-1:0]   wdata_o,
   output logic [AXI_DATA_W/8-1:0] wstrb_o,
   output logic                    wlast_o,
   output logic                    wvalid_o,
   input  wire                     wready_i,
   input  wire [1:0]               bresp_i,
   input  wire                     bvalid_i,
   output logic                    bready_o,
   output logic                    idle_o,
   output logic                    resp_err_o
);

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_ADDR,
      WR_DATA,
      WR_RESP
   } writer_state_t;

   writer_state_t          state_q;
   logic [AXI_ADDR_W-1:0]  addr_q;
   logic [BURST_LEN_W-1:0] len_q;
   logic [BURST_LEN_W-1:0] beat_q;

   assign idle_o    = (state_q == WR_IDLE);
   assign cmd_pop_o = idle_o && !cmd_empty_i;

   // Address channel
   assign awvalid_o = (state_q == WR_ADDR);
   assign awaddr_o  = addr_q;
   assign awlen_o   = AXI_LEN_W'(len_q - 1'b1);
   assign awburst_o = AXI_BURST_INCR;
   assign awsize_o  = 3'($clog2(AXI_DATA_W / 8));

   // Data channel, words come straight from the FIFO head
   assign wvalid_o   = (state_q == WR_DATA) && !data_empty_i;
   assign wdata_o    = data_i;
   assign wstrb_o    = '1;
   assign wlast_o    = (state_q == WR_DATA) && (beat_q == len_q);
   assign data_pop_o = wvalid_o && wready_i;

   // Response channel
   assign bready_o   = (state_q == WR_RESP);
   assign resp_err_o = bready_o && bvalid_i && (bresp_i != AXI_RESP_OKAY);

   always_ff @(posedge clk_i) begin
      if (cmd_pop_o) begin
         addr_q <= cmd_i.addr;
         len_q  <= cmd_i.len;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= WR_IDLE;
         beat_q  <= '0;
      end else begin
         case (state_q)
            WR_IDLE: begin
               if (cmd_pop_o) begin
                  state_q <= WR_ADDR;
                  beat_q  <= BURST_LEN_W'(1);
               end
            end
            WR_ADDR: begin
               if (awready_i) begin
                  state_q <= WR_DATA;
               end
            end
            WR_DATA: begin
               if (data_pop_o) begin
                  if (wlast_o) begin
                     state_q <= WR_RESP;
                  end else begin
                     beat_q <= beat_q + 1'b1;
                  end
               end
            end
            default: begin
               if (bvalid_i) begin
                  state_q <= WR_IDLE;
               end
            end
         endcase
      end
   end

   a_aw_stable : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o)
   );

   // Held beat relies on the FIFO head not moving
   a_w_stable : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o)
   );

endmodule

`default_nettype wire

// File: design/dma_axi_pkg.sv
`default_nettype none

package dma_axi_pkg;

   // Byte address width
   localparam int AXI_ADDR_W = 32;

   // One data word is four bytes
   localparam int AXI_DATA_W = 32;

   // awlen holds the beat count minus one
   localparam int AXI_LEN_W = 8;

   // Burst type
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

   // Write response
   localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: design/dma_burst_planner.sv
`timescale 1ns/1ns
`default_nettype none

module dma_burst_planner
   import dma_axi_pkg::*;
   import dma_xfer_pkg::*;
#(
   parameter int DATA_DEPTH_W = 5
) (
   input  wire                   clk_i,
   input  wire                   rst_n_i,
   input  wire                   start_i,
   input  wire [AXI_ADDR_W-1:0]  addr_i,
   input  wire [XFER_LEN_W-1:0]  length_i,
   input  wire [BURST_LEN_W-1:0] max_len_i,
   input  wire                   word_in_i,
   input  wire                   cmd_full_i,
   input  wire                   cmd_empty_i,
   output logic                  cmd_push_o,
   output burst_cmd_t            cmd_o,
   input  wire                   writer_idle_i,
   input  wire                   resp_err_i,
   output logic                  busy_o,
   output logic                  error_o,
   output logic [XFER_LEN_W-1:0] remaining_o
);

   localparam int CNT_W = DATA_DEPTH_W + 1;
   localparam int CMP_W = XFER_LEN_W + 1;

   planner_state_t         state_q;
   planner_state_t         state_d;
   logic [AXI_ADDR_W-1:0]  addr_q;
   logic [AXI_ADDR_W-1:0]  addr_d;
   logic [XFER_LEN_W-1:0]  remaining_q;
   logic [XFER_LEN_W-1:0]  remaining_d;
   logic [CNT_W-1:0]       uncommitted_q;
   logic [CNT_W-1:0]       uncommitted_d;
   logic [BURST_LEN_W-1:0] burst_len;
   logic [CMP_W-1:0]       avail;
   logic [CMP_W-1:0]       rem;
   logic [CMP_W-1:0]       max_len;

   assign avail   = CMP_W'(uncommitted_q);
   assign rem     = CMP_W'(remaining_q);
   assign max_len = CMP_W'(max_len_i);

   // Whole remainder if buffered and it fits, else a full burst
   always_comb begin
      burst_len = '0;
      if (state_q == COLLECT && rem != '0 && !cmd_full_i) begin
         if (avail >= rem && rem <= max_len) begin
            burst_len = remaining_q[BURST_LEN_W-1:0];
         end else if (avail >= max_len) begin
            burst_len = max_len_i;
         end
      end
   end

   assign cmd_push_o = (burst_len != '0);
   assign cmd_o      = '{addr: addr_q, len: burst_len};

   always_comb begin
      state_d     = state_q;
      addr_d      = addr_q;
      remaining_d = remaining_q;
      case (state_q)
         IDLE: begin
            if (start_i) begin
               state_d     = COLLECT;
               addr_d      = addr_i;
               remaining_d = length_i;
            end
         end
         default: begin
            if (cmd_push_o) begin
               addr_d      = addr_q + (AXI_ADDR_W'(burst_len) << 2);
               remaining_d = remaining_q - XFER_LEN_W'(burst_len);
            end else if (remaining_q == '0 && cmd_empty_i && writer_idle_i) begin
               state_d = IDLE;
            end
         end
      endcase
   end

   // Words in the data FIFO not yet claimed by a burst
   always_comb begin
      uncommitted_d = uncommitted_q;
      if (word_in_i) begin
         uncommitted_d = uncommitted_d + 1'b1;
      end
      if (cmd_push_o) begin
         uncommitted_d = uncommitted_d - CNT_W'(burst_len);
      end
   end

   always_ff @(posedge clk_i) begin
      addr_q <= addr_d;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q       <= IDLE;
         remaining_q   <= '0;
         uncommitted_q <= '0;
         error_o       <= 1'b0;
      end else begin
         state_q       <= state_d;
         remaining_q   <= remaining_d;
         uncommitted_q <= uncommitted_d;
         if (start_i && state_q == IDLE) begin
            error_o <= 1'b0;
         end else if (resp_err_i) begin
            error_o <= 1'b1;
         end
      end
   end

   assign busy_o      = (state_q == COLLECT);
   assign remaining_o = remaining_q;

   a_burst_len_range : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      cmd_push_o |-> (cmd_o.len >= 1 && cmd_o.len <= max_len_i)
   );

   // Next transfer only after busy has dropped
   a_start_not_busy : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      start_i |-> !busy_o
   );

endmodule

`default_nettype wire

// File: design/dma_sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module dma_sync_fifo #(
   parameter type T       = logic [31:0],
   parameter int  DEPTH_W = 5
) (
   input  wire              clk_i,
   input  wire              rst_n_i,
   input  wire              push_i,
   input  wire T            wdata_i,
   output logic             full_o,
   input  wire              pop_i,
   output T                 rdata_o,
   output logic             empty_o,
   output logic [DEPTH_W:0] level_o
);

   localparam int DEPTH = 2 ** DEPTH_W;

   T                   mem [DEPTH];
   logic [DEPTH_W-1:0] wr_ptr_q;
   logic [DEPTH_W-1:0] rd_ptr_q;
   logic [DEPTH_W:0]   count_q;

   // Top bit of the count is set only at DEPTH entries
   assign full_o  = count_q[DEPTH_W];
   assign empty_o = (count_q == '0);
   assign level_o = count_q;

   // Show-ahead read
   assign rdata_o = mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem[wr_ptr_q] <= wdata_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // Push together with pop keeps the level
         case ({push_i, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Producer honours full
   a_no_push_full : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      push_i |-> !full_o
   );

   // Consumer honours empty
   a_no_pop_empty : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      pop_i |-> !empty_o
   );

endmodule

`default_nettype wire

// File: design/dma_write_top.sv
`timescale 1ns/1ns
`default_nettype none

module dma_write_top
   import dma_axi_pkg::*;
   import dma_xfer_pkg::*;
#(
   parameter int DATA_DEPTH_W = 5,
   parameter int CMD_DEPTH_W  = 2
) (
   input  wire                     clk_i,
   input  wire                     rst_n_i,
   input  wire                     stream_tvalid_i,
   input  wire [AXI_DATA_W-1:0]    stream_tdata_i,
   output logic                    stream_tready_o,
   input  wire                     start_i,
   input  wire [AXI_ADDR_W-1:0]    addr_i,
   input  wire [XFER_LEN_W-1:0]    length_i,
   input  wire [BURST_LEN_W-1:0]   max_len_i,
   output logic                    busy_o,
   output logic                    error_o,
   output logic [AXI_ADDR_W-1:0]   awaddr_o,
   output logic [AXI_LEN_W-1:0]    awlen_o,
   output logic [1:0]              awburst_o,
   output logic [2:0]              awsize_o,
   output logic                    awvalid_o,
   input  wire                     awready_i,
   output logic [AXI_DATA_W-1:0]   wdata_o,
   output logic [AXI_DATA_W/8-1:0] wstrb_o,
   output logic                    wlast_o,
   output logic                    wvalid_o,
   input  wire                     wready_i,
   input  wire [1:0]               bresp_i,
   input  wire                     bvalid_i,
   output logic                    bready_o
);

   logic                  data_push;
   logic                  data_full;
   logic                  data_pop;
   logic                  data_empty;
   logic [AXI_DATA_W-1:0] data_rdata;
   logic                  cmd_push;
   logic                  cmd_full;
   logic                  cmd_pop;
   logic                  cmd_empty;
   burst_cmd_t            cmd_wdata;
   burst_cmd_t            cmd_rdata;
   logic                  writer_idle;
   logic                  resp_err;

   // Stream handshake
   assign stream_tready_o = !data_full;
   assign data_push       = stream_tvalid_i && !data_full;

   dma_sync_fifo #(
      .T       (logic [AXI_DATA_W-1:0]),
      .DEPTH_W (DATA_DEPTH_W)
   ) i_data_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (data_push),
      .wdata_i (stream_tdata_i),
      .full_o  (data_full),
      .pop_i   (data_pop),
      .rdata_o (data_rdata),
      .empty_o (data_empty),
      .level_o ()
   );

   dma_burst_planner #(
      .DATA_DEPTH_W (DATA_DEPTH_W)
   ) i_planner (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .start_i       (start_i),
      .addr_i        (addr_i),
      .length_i      (length_i),
      .max_len_i     (max_len_i),
      .word_in_i     (data_push),
      .cmd_full_i    (cmd_full),
      .cmd_empty_i   (cmd_empty),
      .cmd_push_o    (cmd_push),
      .cmd_o         (cmd_wdata),
      .writer_idle_i (writer_idle),
      .resp_err_i    (resp_err),
      .busy_o        (busy_o),
      .error_o       (error_o),
      .remaining_o   ()
   );

   dma_sync_fifo #(
      .T       (burst_cmd_t),
      .DEPTH_W (CMD_DEPTH_W)
   ) i_cmd_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (cmd_push),
      .wdata_i (cmd_wdata),
      .full_o  (cmd_full),
      .pop_i   (cmd_pop),
      .rdata_o (cmd_rdata),
      .empty_o (cmd_empty),
      .level_o ()
   );

   dma_axi_burst_writer i_writer (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cmd_i        (cmd_rdata),
      .cmd_empty_i  (cmd_empty),
      .cmd_pop_o    (cmd_pop),
      .data_i       (data_rdata),
      .data_empty_i (data_empty),
      .data_pop_o   (data_pop),
      .awaddr_o     (awaddr_o),
      .awlen_o      (awlen_o),
      .awburst_o    (awburst_o),
      .awsize_o     (awsize_o),
      .awvalid_o    (awvalid_o),
      .awready_i    (awready_i),
      .wdata_o      (wdata_o),
      .wstrb_o      (wstrb_o),
      .wlast_o      (wlast_o),
      .wvalid_o     (wvalid_o),
      .wready_i     (wready_i),
      .bresp_i      (bresp_i),
      .bvalid_i     (bvalid_i),
      .bready_o     (bready_o),
      .idle_o       (writer_idle),
      .resp_err_o   (resp_err)
   );

endmodule

`default_nettype wire

// File: design/dma_xfer_pkg.sv
`default_nettype none

package dma_xfer_pkg;

   import dma_axi_pkg::*;

   // Word count of a whole transfer
   localparam int XFER_LEN_W = 16;

   // Burst size in words, 1 to 256
   localparam int BURST_LEN_W = AXI_LEN_W + 1;

   typedef struct packed {
      logic [AXI_ADDR_W-1:0]  addr;
      logic [BURST_LEN_W-1:0] len;
   } burst_cmd_t;

   typedef enum logic {
      IDLE,
      COLLECT
   } planner_state_t;

endpackage

`default_nettype wire

// File: sim.f
design/dma_axi_pkg.sv
design/dma_xfer_pkg.sv
design/dma_sync_fifo.sv
design/dma_burst_planner.sv
design/dma_axi_burst_writer.sv
design/dma_write_top.sv
verif/axi_mem_model.sv
verif/dma_write_tb.sv

// File: verif/axi_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model
   import dma_axi_pkg::*;
#(
   parameter int SEED = 6
) (
   input  wire                  clk_i,
   input  wire                  rst_n_i,
   input  wire [AXI_ADDR_W-1:0] awaddr_i,
   input  wire [AXI_LEN_W-1:0]  awlen_i,
   input  wire                  awvalid_i,
   output logic                 awready_o,
   input  wire [AXI_DATA_W-1:0] wdata_i,
   input  wire                  wlast_i,
   input  wire                  wvalid_i,
   output logic                 wready_o,
   output logic [1:0]           bresp_o,
   output logic                 bvalid_o,
   input  wire                  bready_i,
   input  wire                  heavy_i,
   input  wire [AXI_ADDR_W-1:0] err_lo_i,
   input  wire [AXI_ADDR_W-1:0] err_hi_i
);

   localparam int         MEM_AW      = 12;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic [AXI_DATA_W-1:0] mem [2**MEM_AW];
   logic [AXI_ADDR_W-1:0] aw_addr_log [64];
   int                    aw_len_log [64];
   int                    word_cnt;
   int                    burst_cnt;
   logic [MEM_AW-1:0]     wr_idx;
   logic                  err_q;
   logic                  resp_pend;
   logic                  stalled;
   int                    hold;
   integer                seed;

   initial begin
      seed      = SEED;
      stalled   = 1'b0;
      hold      = 0;
      awready_o = 1'b0;
      wready_o  = 1'b0;
      bvalid_o  = 1'b0;
      bresp_o   = AXI_RESP_OKAY;
      // Every word starts with a value tied to its full index
      for (int i = 0; i < 2**MEM_AW; i++) begin
         mem[MEM_AW'(i)] = 32'ha500_0000 ^ (32'(i) * 32'h0001_0001);
      end
   end

   always @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         word_cnt  <= 0;
         burst_cnt <= 0;
         wr_idx    <= '0;
         err_q     <= 1'b0;
         resp_pend <= 1'b0;
      end else begin
         if (awvalid_i && awready_o) begin
            wr_idx                    <= awaddr_i[MEM_AW+1:2];
            err_q                     <= (awaddr_i >= err_lo_i) && (awaddr_i < err_hi_i);
            aw_addr_log[6'(burst_cnt)] <= awaddr_i;
            aw_len_log[6'(burst_cnt)]  <= 32'(awlen_i);
            burst_cnt                 <= burst_cnt + 1;
         end
         if (wvalid_i && wready_o) begin
            mem[wr_idx] <= wdata_i;
            wr_idx      <= wr_idx + 1'b1;
            word_cnt    <= word_cnt + 1;
            if (wlast_i) begin
               resp_pend <= 1'b1;
            end
         end
         if (bvalid_o && bready_i) begin
            resp_pend <= 1'b0;
         end
      end
   end

   // Heavy mode alternates long stalls with short ready windows
   always @(negedge clk_i) begin
      if (heavy_i) begin
         if (hold == 0) begin
            stalled = !stalled;
            hold    = stalled ? 36 + ($random(seed) & 15) : 2 + ($random(seed) & 7);
         end
         hold      = hold - 1;
         awready_o = !stalled && (($random(seed) & 3) != 0);
         wready_o  = !stalled && (($random(seed) & 3) != 0);
      end else begin
         stalled   = 1'b0;
         hold      = 0;
         awready_o = ($random(seed) & 3) != 0;
         wready_o  = ($random(seed) & 3) != 0;
      end
      bvalid_o = resp_pend;
      bresp_o  = err_q ? RESP_SLVERR : AXI_RESP_OKAY;
   end

endmodule

`default_nettype wire

// File: verif/dma_write_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dma_write_tb
   import dma_axi_pkg::*;
   import dma_xfer_pkg::*;
();

   localparam int CLK_PERIOD     = 8;
   localparam int SEED           = 6;
   localparam int TOTAL_WORDS    = 1 + 37 + 64;
   localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 8 + 2000;

   logic                    clk;
   logic                    rst_n;
   logic                    stream_tvalid;
   logic [AXI_DATA_W-1:0]   stream_tdata;
   logic                    stream_tready;
   logic                    start;
   logic [AXI_ADDR_W-1:0]   addr;
   logic [XFER_LEN_W-1:0]   length;
   logic [BURST_LEN_W-1:0]  max_len;
   logic                    busy;
   logic                    error;
   logic [AXI_ADDR_W-1:0]   awaddr;
   logic [AXI_LEN_W-1:0]    awlen;
   logic [1:0]              awburst;
   logic [2:0]              awsize;
   logic                    awvalid;
   logic                    awready;
   logic [AXI_DATA_W-1:0]   wdata;
   logic [AXI_DATA_W/8-1:0] wstrb;
   logic                    wlast;
   logic                    wvalid;
   logic                    wready;
   logic [1:0]              bresp;
   logic                    bvalid;
   logic                    bready;
   logic                    heavy;
   logic [AXI_ADDR_W-1:0]   err_lo;
   logic [AXI_ADDR_W-1:0]   err_hi;
   integer                  seed;
   int                      cycles = 0;
   int                      beat;
   int                      burst_beats;
   logic [AXI_ADDR_W-1:0]   next_awaddr;
   logic [AXI_DATA_W-1:0]   exp_data [256];

   dma_write_top #(
      .DATA_DEPTH_W (5),
      .CMD_DEPTH_W  (2)
   ) i_dut (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .stream_tvalid_i (stream_tvalid),
      .stream_tdata_i  (stream_tdata),
      .stream_tready_o (stream_tready),
      .start_i         (start),
      .addr_i          (addr),
      .length_i        (length),
      .max_len_i       (max_len),
      .busy_o          (busy),
      .error_o         (error),
      .awaddr_o        (awaddr),
      .awlen_o         (awlen),
      .awburst_o       (awburst),
      .awsize_o        (awsize),
      .awvalid_o       (awvalid),
      .awready_i       (awready),
      .wdata_o         (wdata),
      .wstrb_o         (wstrb),
      .wlast_o         (wlast),
      .wvalid_o        (wvalid),
      .wready_i        (wready),
      .bresp_i         (bresp),
      .bvalid_i        (bvalid),
      .bready_o        (bready)
   );

   axi_mem_model #(
      .SEED (SEED)
   ) i_mem (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .awaddr_i  (awaddr),
      .awlen_i   (awlen),
      .awvalid_i (awvalid),
      .awready_o (awready),
      .wdata_i   (wdata),
      .wlast_i   (wlast),
      .wvalid_i  (wvalid),
      .wready_o  (wready),
      .bresp_o   (bresp),
      .bvalid_o  (bvalid),
      .bready_i  (bready),
      .heavy_i   (heavy),
      .err_lo_i  (err_lo),
      .err_hi_i  (err_hi)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic report_problem(input string what);
      $display("Error at %0t ns: %s", $time, what);
      $display("Testbench failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "run stopped at the first mismatch");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual == expected)
         else report_mismatch(name, expected, actual);
   endtask

   function automatic logic [31:0] fill_word(input int index);
      return 32'ha500_0000 ^ (32'(index) * 32'h0001_0001);
   endfunction

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES) begin
         report_problem($sformatf("transfers did not finish within %0d cycles", TIMEOUT_CYCLES));
      end
   end

   // Burst checks on each AXI handshake
   always @(posedge clk) begin
      if (start) begin
         next_awaddr <= addr;
      end
      if (awvalid && awready) begin
         assert (32'(awlen) < 32'(max_len))
            else report_problem("burst longer than max_len_i");
         check_value("awaddr", next_awaddr, awaddr);
         // INCR burst code and four-byte beats
         check_value("awburst", 32'd1, 32'(awburst));
         check_value("awsize", 32'd2, 32'(awsize));
         next_awaddr <= next_awaddr + ((32'(awlen) + 32'd1) << 2);
         burst_beats <= 32'(awlen) + 1;
         beat        <= 0;
      end
      if (wvalid && wready) begin
         check_value("wlast", 32'(beat + 1 == burst_beats), 32'(wlast));
         check_value("wstrb", 32'hf, 32'(wstrb));
         beat <= beat + 1;
      end
      // The model answers on the cycle after the last beat
      if (rst_n) begin
         check_value("bready_o", 32'(bvalid), 32'(bready));
      end
   end

   task automatic run_transfer(input logic [AXI_ADDR_W-1:0] base, input int words,
                               input int max, input logic stall, input logic inject);
      int   k;
      int   first_burst;
      int   first_word;
      int   len_sum;
      int   idx;
      logic saw_low;
      first_burst = i_mem.burst_cnt;
      first_word  = i_mem.word_cnt;
      len_sum     = 0;
      idx         = int'(base >> 2);
      saw_low     = 1'b0;
      for (k = 0; k < words; k++) begin
         exp_data[8'(k)] = $random(seed);
      end
      @(negedge clk);
      addr    = base;
      length  = XFER_LEN_W'(words);
      max_len = BURST_LEN_W'(max);
      heavy   = stall;
      err_lo  = base;
      err_hi  = inject ? base + 4 : base;
      start   = 1'b1;
      @(negedge clk);
      start = 1'b0;
      check_value("busy_o", 32'd1, 32'(busy));
      check_value("error_o", 32'd0, 32'(error));
      // Handshake at the coming edge is known from the levels here
      k = 0;
      while (k < words) begin
         if (stall || ($random(seed) & 3) != 0) begin
            stream_tvalid = 1'b1;
            stream_tdata  = exp_data[8'(k)];
         end else begin
            stream_tvalid = 1'b0;
         end
         if (!stream_tready) begin
            saw_low = 1'b1;
         end
         if (stream_tvalid && stream_tready) begin
            k++;
         end
         @(negedge clk);
      end
      stream_tvalid = 1'b0;
      while (busy) begin
         @(negedge clk);
      end
      heavy = 1'b0;
      check_value("error_o", 32'(inject), 32'(error));
      check_value("word count", 32'(first_word + words), 32'(i_mem.word_cnt));
      check_value("pending response", 32'd0, 32'(i_mem.resp_pend));
      check_value("first awaddr", base, i_mem.aw_addr_log[6'(first_burst)]);
      for (k = first_burst; k < i_mem.burst_cnt; k++) begin
         len_sum += i_mem.aw_len_log[6'(k)] + 1;
      end
      check_value("burst length sum", 32'(words), 32'(len_sum));
      for (k = 0; k < words; k++) begin
         check_value($sformatf("mem word %0h", idx + k), exp_data[8'(k)],
                     i_mem.mem[12'(idx + k)]);
      end
      // Neighbours keep their fill
      check_value("word below", fill_word(idx - 1), i_mem.mem[12'(idx - 1)]);
      check_value("word above", fill_word(idx + words), i_mem.mem[12'(idx + words)]);
      if (stall) begin
         assert (saw_low)
            else report_problem("stream_tready_o never fell while the AXI side stalled");
      end
   endtask

   initial begin
      seed          = SEED;
      rst_n         = 1'b0;
      stream_tvalid = 1'b0;
      stream_tdata  = '0;
      start         = 1'b0;
      addr          = '0;
      length        = '0;
      max_len       = '0;
      heavy         = 1'b0;
      err_lo        = '0;
      err_hi        = '0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_value("busy_o", 32'd0, 32'(busy));
      check_value("error_o", 32'd0, 32'(error));
      check_value("awvalid_o", 32'd0, 32'(awvalid));
      check_value("wvalid_o", 32'd0, 32'(wvalid));
      check_value("stream_tready_o", 32'd1, 32'(stream_tready));
      run_transfer(32'h0000_0100, 1, 4, 1'b0, 1'b0);
      // First burst of this one gets an error response
      run_transfer(32'h0000_1000, 37, 8, 1'b0, 1'b1);
      run_transfer(32'h0000_2000, 64, 16, 1'b1, 1'b0);
      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire
